//--- cpu20.f
verilog/cpu20_pkg.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/cpu20_top.sv
tests/cpu20_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cpu20_tb
FILELIST = cpu20.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tests/cpu20_tb.sv
// Testbench for the 20-bit three-stage core
// Clock, reset, directed and LCG stimulus, reference model, retire checks
`timescale 1ns/100ps

module cpu20_tb;

    localparam int NUM_INSTR   = 400;
    localparam int READY_LIMIT = 4;     // Hazard stall lasts two cycles at most
    localparam int DRAIN_LIMIT = 20;
    localparam int REC_W       = 51;    // Packed retire record with flags

    logic                 clk = 1'b0;   // No edge at time zero
    logic                 reset;
    logic                 instr_valid;
    cpu20_pkg::instr_t    instr;
    logic                 instr_ready;
    logic                 retire_valid;
    logic                 retire_we1;
    cpu20_pkg::reg_addr_t retire_dest1;
    cpu20_pkg::word_t     retire_data1;
    logic                 retire_we2;
    cpu20_pkg::reg_addr_t retire_dest2;
    cpu20_pkg::word_t     retire_data2;
    logic                 flag_zero, flag_sign, flag_carry;

    cpu20_pkg::word_t     m_regs [8];       // Reference model registers
    logic                 m_zero, m_sign, m_carry;
    int                   due_q [$];        // Cycle at which each retire shows
    logic [REC_W-1:0]     rec_q [$];
    logic [REC_W-1:0]     got_rec;
    logic                 due_now;
    logic [31:0]          lcg_state;
    logic [31:0]          idle_pick;
    cpu20_pkg::opcode_t   kept_ops [16];
    int                   cycle = 0;
    int                   sent, retired, stalls, waited;

    cpu20_top DUT (
        .clk, .reset, .instr_valid, .instr, .instr_ready,
        .retire_valid, .retire_we1, .retire_dest1, .retire_data1,
        .retire_we2, .retire_dest2, .retire_data2,
        .flag_zero, .flag_sign, .flag_carry
    );

    initial begin
        forever #5 clk = ~clk;          // 10 ns period
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic cpu20_pkg::instr_t encode(input cpu20_pkg::opcode_t op,
                                                 input int s1, input int s2,
                                                 input int d1, input int d2);
        return {op, 3'(s1), 3'(s2), 3'(d1), 3'(d2), 2'b11};   // Bits 1..0 ignored
    endfunction

    function automatic logic [REC_W-1:0] pack_retire(
        input logic we1, input cpu20_pkg::reg_addr_t d1, input cpu20_pkg::word_t v1,
        input logic we2, input cpu20_pkg::reg_addr_t d2, input cpu20_pkg::word_t v2,
        input logic z, input logic s, input logic c);
        // Destination and data count only for a port that writes
        return {we1, we1 ? d1 : 3'd0, we1 ? v1 : 20'd0,
                we2, we2 ? d2 : 3'd0, we2 ? v2 : 20'd0, z, s, c};
    endfunction

    task automatic stop_with(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // Sequential semantics of one instruction, expected record queued
    task automatic model_apply(input cpu20_pkg::instr_t word);
        cpu20_pkg::opcode_t op;
        cpu20_pkg::word_t   a, b, r1, r2;
        logic [2:0]         d1, d2;
        logic               w1, w2;
        op = word[cpu20_pkg::OPC_LSB +: 6];
        a  = m_regs[word[cpu20_pkg::SRC1_LSB +: 3]];
        b  = m_regs[word[cpu20_pkg::SRC2_LSB +: 3]];
        d1 = word[cpu20_pkg::DST1_LSB +: 3];
        d2 = word[cpu20_pkg::DST2_LSB +: 3];
        r1 = '0;
        r2 = '0;
        w1 = op inside {cpu20_pkg::OP_NOT, cpu20_pkg::OP_AND, cpu20_pkg::OP_OR,
                        cpu20_pkg::OP_XOR, cpu20_pkg::OP_SHFTR, cpu20_pkg::OP_SHFTL,
                        cpu20_pkg::OP_ROTR, cpu20_pkg::OP_ROTL, cpu20_pkg::OP_SWAP,
                        cpu20_pkg::OP_INC};
        w2 = (op == cpu20_pkg::OP_SWAP);
        case (op)
            cpu20_pkg::OP_NOT:   r1 = ~a;
            cpu20_pkg::OP_AND:   r1 = a & b;
            cpu20_pkg::OP_OR:    r1 = a | b;
            cpu20_pkg::OP_XOR:   r1 = a ^ b;
            cpu20_pkg::OP_SHFTR: begin
                r1      = a >> 1;
                m_carry = a[0];             // Bit shifted out
            end
            cpu20_pkg::OP_SHFTL: begin
                r1      = a << 1;
                m_carry = a[19];
            end
            cpu20_pkg::OP_ROTR:  r1 = {a[0], a[19:1]};
            cpu20_pkg::OP_ROTL:  r1 = {a[18:0], a[19]};
            cpu20_pkg::OP_INC: begin
                r1      = a + 20'd1;
                m_carry = (a == 20'hfffff); // Wrap to zero
            end
            cpu20_pkg::OP_SWAP: begin
                r1 = b;
                r2 = a;
            end
            cpu20_pkg::OP_EQ:    m_zero = (a == b);
            cpu20_pkg::OP_GT:    m_sign = (a > b);
            cpu20_pkg::OP_LT:    m_sign = (a < b);
            cpu20_pkg::OP_GET: begin
                m_sign = (a > b);
                m_zero = (a == b);
            end
            cpu20_pkg::OP_LET: begin
                m_sign = (a < b);
                m_zero = (a == b);
            end
            default: ;                  // NOP, dropped and undefined
        endcase
        // Rotates and SWAP leave the zero flag alone
        if (op inside {cpu20_pkg::OP_NOT, cpu20_pkg::OP_AND, cpu20_pkg::OP_OR,
                       cpu20_pkg::OP_XOR, cpu20_pkg::OP_SHFTR, cpu20_pkg::OP_SHFTL,
                       cpu20_pkg::OP_INC}) begin
            m_zero = (r1 == '0);
        end
        if (w1) m_regs[d1] = r1;
        if (w2) m_regs[d2] = r2;        // Second port wins on equal destinations
        due_q.push_back(cycle + 3);
        rec_q.push_back(pack_retire(w1, d1, r1, w2, d2, r2, m_zero, m_sign, m_carry));
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the transfer edge
    task automatic issue(input cpu20_pkg::instr_t word);
        int tries;
        instr_valid = 1'b1;
        instr       = word;
        tries       = 0;
        @(negedge clk);
        while (!instr_ready) begin
            stalls++;
            tries++;
            if (tries > READY_LIMIT) stop_with("instr_ready stayed low for too long");
            @(negedge clk);
        end
        model_apply(word);
        sent++;
        @(posedge clk);
        #1 instr_valid = 1'b0;
    endtask

    function automatic cpu20_pkg::instr_t random_instr();
        logic [31:0] r;
        logic [31:0] f;
        cpu20_pkg::opcode_t op;
        r = next_random();
        f = next_random();
        if (r[31:28] == 4'd0) op = r[27:22];   // Mostly undefined or dropped
        else                  op = kept_ops[r[27:24]];
        return {op, f[31:18]};
    endfunction

    always @(negedge clk) begin
        if (reset) begin
            assert (!retire_valid && instr_ready && !flag_zero && !flag_sign && !flag_carry)
                else stop_with($sformatf("[ERROR] t=%0t outputs not idle in reset", $time));
        end else begin
            due_now = (due_q.size() > 0) && (due_q[0] == cycle);
            assert (retire_valid == due_now)
                else stop_with($sformatf("[ERROR] t=%0t retire_valid=%0b expected %0b",
                                         $time, retire_valid, due_now));
            if (retire_valid) begin
                got_rec = pack_retire(retire_we1, retire_dest1, retire_data1,
                                      retire_we2, retire_dest2, retire_data2,
                                      flag_zero, flag_sign, flag_carry);
                assert (got_rec == rec_q[0])
                    else stop_with($sformatf("[ERROR] t=%0t retire record %h expected %h",
                                             $time, got_rec, rec_q[0]));
                void'(due_q.pop_front());
                void'(rec_q.pop_front());
                retired++;
            end
        end
    end

    initial begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        lcg_state   = 32'h8f86_0a4e;
        sent        = 0;
        retired     = 0;
        stalls      = 0;
        m_zero      = 1'b0;
        m_sign      = 1'b0;
        m_carry     = 1'b0;
        for (int i = 0; i < 8; i++) m_regs[i] = '0;
        kept_ops = '{cpu20_pkg::OP_NOP, cpu20_pkg::OP_NOT, cpu20_pkg::OP_AND,
                     cpu20_pkg::OP_OR, cpu20_pkg::OP_XOR, cpu20_pkg::OP_SHFTR,
                     cpu20_pkg::OP_SHFTL, cpu20_pkg::OP_ROTR, cpu20_pkg::OP_ROTL,
                     cpu20_pkg::OP_SWAP, cpu20_pkg::OP_INC, cpu20_pkg::OP_EQ,
                     cpu20_pkg::OP_GT, cpu20_pkg::OP_LT, cpu20_pkg::OP_GET,
                     cpu20_pkg::OP_LET};
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        assert (!retire_valid && instr_ready && !flag_zero && !flag_sign && !flag_carry)
            else stop_with($sformatf("[ERROR] t=%0t outputs not idle after reset", $time));
        @(posedge clk);
        #1;
        issue(encode(cpu20_pkg::OP_NOT,   0, 0, 1, 0));    // r1 all ones
        issue(encode(cpu20_pkg::OP_INC,   1, 1, 2, 0));    // Wrap, dependent on r1
        issue(encode(cpu20_pkg::OP_SHFTR, 1, 1, 3, 0));
        issue(encode(cpu20_pkg::OP_SHFTL, 3, 3, 4, 0));
        issue(encode(cpu20_pkg::OP_SHFTL, 1, 1, 5, 0));    // Carry out of bit 19
        issue(encode(cpu20_pkg::OP_ROTR,  4, 4, 6, 0));
        issue(encode(cpu20_pkg::OP_ROTL,  3, 3, 7, 0));
        issue(encode(cpu20_pkg::OP_SWAP,  3, 4, 5, 6));
        issue(encode(cpu20_pkg::OP_SWAP,  1, 2, 7, 7));    // Same destination twice
        issue(encode(cpu20_pkg::OP_EQ,    7, 1, 0, 0));
        issue(encode(cpu20_pkg::OP_GT,    3, 4, 0, 0));
        issue(encode(cpu20_pkg::OP_LT,    3, 4, 0, 0));
        issue(encode(cpu20_pkg::OP_GET,   1, 7, 0, 0));
        issue(encode(cpu20_pkg::OP_LET,   2, 1, 0, 0));
        issue(encode(cpu20_pkg::OP_AND,   1, 3, 0, 0));
        issue(encode(cpu20_pkg::OP_OR,    0, 6, 2, 0));
        issue(encode(cpu20_pkg::OP_XOR,   2, 5, 3, 0));
        issue(encode(cpu20_pkg::OP_NOP,   3, 3, 3, 3));
        issue(encode(6'd20, 1, 2, 3, 4));                  // Dropped arithmetic
        issue(encode(6'd63, 5, 6, 7, 0));                  // Undefined
        while (sent < NUM_INSTR) begin
            issue(random_instr());
            idle_pick = next_random();
            if (idle_pick[31:30] == 2'b00) begin
                repeat (int'(idle_pick[29:28]) + 1) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
        waited = 0;
        while (due_q.size() != 0) begin
            waited++;
            if (waited > DRAIN_LIMIT) stop_with("retire queue did not drain in time");
            @(negedge clk);
        end
        if (retired != sent || stalls == 0) begin
            stop_with($sformatf("%0d transfers, %0d retires, %0d stall cycles",
                                sent, retired, stalls));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- verilog/cpu20_top.sv
// Top level of the 20-bit three-stage core
// Connects decode, execute, writeback and the register file
`timescale 1ns/100ps

module cpu20_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  cpu20_pkg::instr_t    instr,
    output logic                 instr_ready,
    output logic                 retire_valid,
    output logic                 retire_we1,
    output cpu20_pkg::reg_addr_t retire_dest1,
    output cpu20_pkg::word_t     retire_data1,
    output logic                 retire_we2,
    output cpu20_pkg::reg_addr_t retire_dest2,
    output cpu20_pkg::word_t     retire_data2,
    output logic                 flag_zero,
    output logic                 flag_sign,
    output logic                 flag_carry
);

    // Register file reads
    cpu20_pkg::reg_addr_t rd_addr1, rd_addr2;
    cpu20_pkg::word_t     rd_data1, rd_data2;
    // Decode register
    logic                 dec_valid, dec_we1, dec_we2;
    cpu20_pkg::opcode_t   dec_op;
    cpu20_pkg::reg_addr_t dec_dest1, dec_dest2;
    cpu20_pkg::word_t     dec_a, dec_b;
    // Execute register
    logic                 ex_valid, ex_we1, ex_we2;
    cpu20_pkg::reg_addr_t ex_dest1, ex_dest2;
    cpu20_pkg::word_t     ex_data1, ex_data2;
    logic                 ex_zero_en, ex_zero, ex_sign_en, ex_sign, ex_carry_en, ex_carry;
    // Register file writes
    logic                 wb_we1, wb_we2;
    cpu20_pkg::reg_addr_t wb_addr1, wb_addr2;
    cpu20_pkg::word_t     wb_data1, wb_data2;

    decode_stage u_decode (
        .clk, .reset, .instr_valid, .instr, .instr_ready,
        .rd_addr1, .rd_addr2, .rd_data1, .rd_data2,
        .ex_valid, .ex_we1, .ex_we2, .ex_dest1, .ex_dest2,
        .dec_valid, .dec_we1, .dec_we2, .dec_op, .dec_dest1, .dec_dest2, .dec_a, .dec_b
    );

    execute_stage u_execute (
        .clk, .reset,
        .dec_valid, .dec_we1, .dec_we2, .dec_op, .dec_dest1, .dec_dest2, .dec_a, .dec_b,
        .ex_valid, .ex_we1, .ex_we2, .ex_dest1, .ex_dest2, .ex_data1, .ex_data2,
        .ex_zero_en, .ex_zero, .ex_sign_en, .ex_sign, .ex_carry_en, .ex_carry
    );

    writeback_stage u_writeback (
        .clk, .reset,
        .ex_valid, .ex_we1, .ex_we2, .ex_dest1, .ex_dest2, .ex_data1, .ex_data2,
        .ex_zero_en, .ex_zero, .ex_sign_en, .ex_sign, .ex_carry_en, .ex_carry,
        .wb_we1, .wb_we2, .wb_addr1, .wb_addr2, .wb_data1, .wb_data2,
        .retire_valid, .retire_we1, .retire_dest1, .retire_data1,
        .retire_we2, .retire_dest2, .retire_data2,
        .flag_zero, .flag_sign, .flag_carry
    );

    register_file u_regs (
        .clk, .reset,
        .rd_addr1, .rd_addr2, .rd_data1, .rd_data2,
        .wb_we1, .wb_we2, .wb_addr1, .wb_addr2, .wb_data1, .wb_data2
    );

endmodule

//--- verilog/writeback_stage.sv
// Writeback stage
// Register file write ports, flag register and the one-cycle retire record
`timescale 1ns/100ps

module writeback_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ex_valid,
    input  logic                 ex_we1,
    input  logic                 ex_we2,
    input  cpu20_pkg::reg_addr_t ex_dest1,
    input  cpu20_pkg::reg_addr_t ex_dest2,
    input  cpu20_pkg::word_t     ex_data1,
    input  cpu20_pkg::word_t     ex_data2,
    input  logic                 ex_zero_en,
    input  logic                 ex_zero,
    input  logic                 ex_sign_en,
    input  logic                 ex_sign,
    input  logic                 ex_carry_en,
    input  logic                 ex_carry,
    output logic                 wb_we1,
    output logic                 wb_we2,
    output cpu20_pkg::reg_addr_t wb_addr1,
    output cpu20_pkg::reg_addr_t wb_addr2,
    output cpu20_pkg::word_t     wb_data1,
    output cpu20_pkg::word_t     wb_data2,
    output logic                 retire_valid,
    output logic                 retire_we1,
    output cpu20_pkg::reg_addr_t retire_dest1,
    output cpu20_pkg::word_t     retire_data1,
    output logic                 retire_we2,
    output cpu20_pkg::reg_addr_t retire_dest2,
    output cpu20_pkg::word_t     retire_data2,
    output logic                 flag_zero,
    output logic                 flag_sign,
    output logic                 flag_carry
);

    // Register file commits on the same edge the retire record is taken
    assign wb_we1   = ex_valid && ex_we1;
    assign wb_we2   = ex_valid && ex_we2;
    assign wb_addr1 = ex_dest1;
    assign wb_addr2 = ex_dest2;
    assign wb_data1 = ex_data1;
    assign wb_data2 = ex_data2;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            retire_valid <= 1'b0;
            retire_we1   <= 1'b0;
            retire_we2   <= 1'b0;
            flag_zero    <= 1'b0;
            flag_sign    <= 1'b0;
            flag_carry   <= 1'b0;
        end else begin
            retire_valid <= ex_valid;   // High for one cycle per instruction
            retire_we1   <= wb_we1;
            retire_we2   <= wb_we2;
            if (ex_valid && ex_zero_en) begin
                flag_zero <= ex_zero;
            end
            if (ex_valid && ex_sign_en) begin
                flag_sign <= ex_sign;
            end
            if (ex_valid && ex_carry_en) begin
                flag_carry <= ex_carry;  // Other flags keep their value
            end
        end
    end

    always_ff @(posedge clk) begin
        retire_dest1 <= ex_dest1;
        retire_data1 <= ex_data1;
        retire_dest2 <= ex_dest2;
        retire_data2 <= ex_data2;
    end

endmodule

//--- verilog/execute_stage.sv
// Execute stage with the ALU for all supported opcodes
// Registers results, destinations, flag values and per-flag update enables
`timescale 1ns/100ps

module execute_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dec_valid,
    input  logic                 dec_we1,
    input  logic                 dec_we2,
    input  cpu20_pkg::opcode_t   dec_op,
    input  cpu20_pkg::reg_addr_t dec_dest1,
    input  cpu20_pkg::reg_addr_t dec_dest2,
    input  cpu20_pkg::word_t     dec_a,
    input  cpu20_pkg::word_t     dec_b,
    output logic                 ex_valid,
    output logic                 ex_we1,
    output logic                 ex_we2,
    output cpu20_pkg::reg_addr_t ex_dest1,
    output cpu20_pkg::reg_addr_t ex_dest2,
    output cpu20_pkg::word_t     ex_data1,
    output cpu20_pkg::word_t     ex_data2,
    output logic                 ex_zero_en,
    output logic                 ex_zero,
    output logic                 ex_sign_en,
    output logic                 ex_sign,
    output logic                 ex_carry_en,
    output logic                 ex_carry
);

    cpu20_pkg::word_t            res1;
    cpu20_pkg::word_t            res2;
    logic [cpu20_pkg::WORD_W:0]  inc_sum;     // Extra bit holds the wrap
    logic                        res_zero_en; // Zero flag taken from res1
    logic                        zero_en, zero_n;
    logic                        sign_en, sign_n;
    logic                        carry_en, carry_n;

    assign inc_sum = {1'b0, dec_a} + 1'b1;

    always_comb begin
        res1        = '0;
        res2        = dec_a;           // Only SWAP writes port 2
        res_zero_en = 1'b0;
        zero_en     = 1'b0;
        zero_n      = 1'b0;
        sign_en     = 1'b0;
        sign_n      = 1'b0;
        carry_en    = 1'b0;
        carry_n     = 1'b0;
        case (dec_op)
            cpu20_pkg::OP_NOP: begin
                // No result and no flag change
            end
            cpu20_pkg::OP_NOT: begin
                res1        = ~dec_a;
                res_zero_en = 1'b1;
            end
            cpu20_pkg::OP_AND: begin
                res1        = dec_a & dec_b;
                res_zero_en = 1'b1;
            end
            cpu20_pkg::OP_OR: begin
                res1        = dec_a | dec_b;
                res_zero_en = 1'b1;
            end
            cpu20_pkg::OP_XOR: begin
                res1        = dec_a ^ dec_b;
                res_zero_en = 1'b1;
            end
            cpu20_pkg::OP_SHFTR: begin
                res1        = {1'b0, dec_a[cpu20_pkg::WORD_W-1:1]};
                res_zero_en = 1'b1;
                carry_en    = 1'b1;
                carry_n     = dec_a[0];                       // Bit shifted out
            end
            cpu20_pkg::OP_SHFTL: begin
                res1        = {dec_a[cpu20_pkg::WORD_W-2:0], 1'b0};
                res_zero_en = 1'b1;
                carry_en    = 1'b1;
                carry_n     = dec_a[cpu20_pkg::WORD_W-1];
            end
            cpu20_pkg::OP_ROTR: res1 = {dec_a[0], dec_a[cpu20_pkg::WORD_W-1:1]};
            cpu20_pkg::OP_ROTL: res1 = {dec_a[cpu20_pkg::WORD_W-2:0], dec_a[cpu20_pkg::WORD_W-1]};
            cpu20_pkg::OP_SWAP: res1 = dec_b;                 // Port 2 gets a
            cpu20_pkg::OP_INC: begin
                res1        = inc_sum[cpu20_pkg::WORD_W-1:0];
                res_zero_en = 1'b1;
                carry_en    = 1'b1;
                carry_n     = inc_sum[cpu20_pkg::WORD_W];     // All ones wrapped
            end
            cpu20_pkg::OP_EQ: begin
                zero_en = 1'b1;
                zero_n  = (dec_a == dec_b);
            end
            cpu20_pkg::OP_GT: begin
                sign_en = 1'b1;
                sign_n  = (dec_a > dec_b);                    // Unsigned compare
            end
            cpu20_pkg::OP_LT: begin
                sign_en = 1'b1;
                sign_n  = (dec_a < dec_b);
            end
            cpu20_pkg::OP_GET, cpu20_pkg::OP_LET: begin
                zero_en = 1'b1;
                zero_n  = (dec_a == dec_b);
                sign_en = 1'b1;
                sign_n  = (dec_op == cpu20_pkg::OP_GET) ? (dec_a > dec_b) : (dec_a < dec_b);
            end
            default: begin
                // Dropped and undefined opcodes retire as NOP
            end
        endcase
        if (res_zero_en) begin
            zero_en = 1'b1;
            zero_n  = (res1 == '0);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_valid    <= 1'b0;
            ex_we1      <= 1'b0;
            ex_we2      <= 1'b0;
            ex_zero_en  <= 1'b0;
            ex_sign_en  <= 1'b0;
            ex_carry_en <= 1'b0;
        end else begin
            ex_valid    <= dec_valid;   // Moves every cycle, no stall
            ex_we1      <= dec_we1;
            ex_we2      <= dec_we2;
            ex_zero_en  <= zero_en;
            ex_sign_en  <= sign_en;
            ex_carry_en <= carry_en;
        end
    end

    always_ff @(posedge clk) begin
        ex_dest1 <= dec_dest1;
        ex_dest2 <= dec_dest2;
        ex_data1 <= res1;
        ex_data2 <= res2;
        ex_zero  <= zero_n;
        ex_sign  <= sign_n;
        ex_carry <= carry_n;
    end

endmodule

//--- verilog/decode_stage.sv
// Decode stage of the three-stage pipeline
// Instruction handshake, RAW hazard check, operand read and write enables
`timescale 1ns/100ps

module decode_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  cpu20_pkg::instr_t    instr,
    output logic                 instr_ready,
    output cpu20_pkg::reg_addr_t rd_addr1,
    output cpu20_pkg::reg_addr_t rd_addr2,
    input  cpu20_pkg::word_t     rd_data1,
    input  cpu20_pkg::word_t     rd_data2,
    input  logic                 ex_valid,
    input  logic                 ex_we1,
    input  logic                 ex_we2,
    input  cpu20_pkg::reg_addr_t ex_dest1,
    input  cpu20_pkg::reg_addr_t ex_dest2,
    output logic                 dec_valid,
    output logic                 dec_we1,
    output logic                 dec_we2,
    output cpu20_pkg::opcode_t   dec_op,
    output cpu20_pkg::reg_addr_t dec_dest1,
    output cpu20_pkg::reg_addr_t dec_dest2,
    output cpu20_pkg::word_t     dec_a,
    output cpu20_pkg::word_t     dec_b
);

    cpu20_pkg::opcode_t   opc;
    cpu20_pkg::reg_addr_t dst1;
    cpu20_pkg::reg_addr_t dst2;
    logic                 we1;
    logic                 we2;
    logic                 hit_dec;
    logic                 hit_ex;
    logic                 take;

    // True when either source field names the given destination
    function automatic logic reads_reg(input cpu20_pkg::reg_addr_t s1,
                                       input cpu20_pkg::reg_addr_t s2,
                                       input cpu20_pkg::reg_addr_t d);
        return (s1 == d) || (s2 == d);
    endfunction

    // Field split
    assign opc      = instr[cpu20_pkg::OPC_LSB +: cpu20_pkg::OPC_W];
    assign rd_addr1 = instr[cpu20_pkg::SRC1_LSB +: cpu20_pkg::REG_AW];
    assign rd_addr2 = instr[cpu20_pkg::SRC2_LSB +: cpu20_pkg::REG_AW];
    assign dst1     = instr[cpu20_pkg::DST1_LSB +: cpu20_pkg::REG_AW];
    assign dst2     = instr[cpu20_pkg::DST2_LSB +: cpu20_pkg::REG_AW];

    // NOT through INC form one contiguous block of result opcodes
    assign we1 = (opc >= cpu20_pkg::OP_NOT) && (opc <= cpu20_pkg::OP_INC);
    assign we2 = (opc == cpu20_pkg::OP_SWAP);

    // Pending writes still in flight block a dependent read
    assign hit_dec = dec_valid &&
                     ((dec_we1 && reads_reg(rd_addr1, rd_addr2, dec_dest1)) ||
                      (dec_we2 && reads_reg(rd_addr1, rd_addr2, dec_dest2)));
    assign hit_ex  = ex_valid &&
                     ((ex_we1 && reads_reg(rd_addr1, rd_addr2, ex_dest1)) ||
                      (ex_we2 && reads_reg(rd_addr1, rd_addr2, ex_dest2)));

    assign instr_ready = !(hit_dec || hit_ex);
    assign take        = instr_valid && instr_ready;   // Transfer this edge

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dec_valid <= 1'b0;
            dec_we1   <= 1'b0;
            dec_we2   <= 1'b0;
        end else begin
            dec_valid <= take;          // Bubble when nothing is taken
            dec_we1   <= take && we1;
            dec_we2   <= take && we2;
        end
    end

    // Operands and destinations, captured on a transfer only
    always_ff @(posedge clk) begin
        if (take) begin
            dec_op    <= opc;
            dec_dest1 <= dst1;
            dec_dest2 <= dst2;
            dec_a     <= rd_data1;
            dec_b     <= rd_data2;
        end
    end

endmodule

//--- verilog/register_file.sv
// Eight-entry 20-bit register file
// Two combinational read ports, two write ports, port 2 wins on a clash
`timescale 1ns/100ps

module register_file (
    input  logic                 clk,
    input  logic                 reset,
    input  cpu20_pkg::reg_addr_t rd_addr1,
    input  cpu20_pkg::reg_addr_t rd_addr2,
    output cpu20_pkg::word_t     rd_data1,
    output cpu20_pkg::word_t     rd_data2,
    input  logic                 wb_we1,
    input  logic                 wb_we2,
    input  cpu20_pkg::reg_addr_t wb_addr1,
    input  cpu20_pkg::reg_addr_t wb_addr2,
    input  cpu20_pkg::word_t     wb_data1,
    input  cpu20_pkg::word_t     wb_data2
);

    cpu20_pkg::word_t regs [cpu20_pkg::NUM_REGS];

    assign rd_data1 = regs[rd_addr1];   // Read during decode
    assign rd_data2 = regs[rd_addr2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < cpu20_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;              // Architectural reset to zero
            end
        end else begin
            if (wb_we1) begin
                regs[wb_addr1] <= wb_data1;
            end
            if (wb_we2) begin
                regs[wb_addr2] <= wb_data2; // Later assignment takes precedence
            end
        end
    end

endmodule

//--- verilog/cpu20_pkg.sv
// Widths, instruction field positions and opcode values of the 20-bit core
// Vector types for data words, instructions, register indices and opcodes
package cpu20_pkg;

    localparam int WORD_W   = 20;   // Data and instruction width
    localparam int NUM_REGS = 8;    // General registers
    localparam int REG_AW   = 3;    // Register index width
    localparam int OPC_W    = 6;    // Opcode field width

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WORD_W-1:0] instr_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [OPC_W-1:0]  opcode_t;

    // Low bit of each instruction field, bits 1 and 0 unused
    localparam int OPC_LSB  = 14;   // Bits 19..14
    localparam int SRC1_LSB = 11;   // Bits 13..11
    localparam int SRC2_LSB = 8;    // Bits 10..8
    localparam int DST1_LSB = 5;    // Bits 7..5
    localparam int DST2_LSB = 2;    // Bits 4..2

    localparam opcode_t OP_NOP   = 6'd1;
    localparam opcode_t OP_NOT   = 6'd8;    // First opcode with a result
    localparam opcode_t OP_AND   = 6'd9;
    localparam opcode_t OP_OR    = 6'd10;
    localparam opcode_t OP_XOR   = 6'd11;
    localparam opcode_t OP_SHFTR = 6'd12;
    localparam opcode_t OP_SHFTL = 6'd13;
    localparam opcode_t OP_ROTR  = 6'd14;
    localparam opcode_t OP_ROTL  = 6'd15;
    localparam opcode_t OP_SWAP  = 6'd16;   // Only two-destination opcode
    localparam opcode_t OP_INC   = 6'd17;   // Last opcode with a result
    localparam opcode_t OP_EQ    = 6'd23;   // Compares touch flags only
    localparam opcode_t OP_GT    = 6'd24;
    localparam opcode_t OP_LT    = 6'd25;
    localparam opcode_t OP_GET   = 6'd26;
    localparam opcode_t OP_LET   = 6'd27;

endpackage
